//--- hw/rasterPkg.sv
`default_nettype none

package rasterPkg;

	typedef logic [7:0] coordT;   // tile-local pixel coordinate
	typedef logic [15:0] depthT;  // smaller is nearer
	typedef logic [15:0] colorT;
	typedef logic signed [17:0] areaT;

	// one flat-shaded triangle of 80 bits
	typedef struct packed {
		coordT x0;
		coordT y0;
		coordT x1;
		coordT y1;
		coordT x2;
		coordT y2;
		depthT depth;
		colorT color;
	} triangleT;

	localparam colorT backgroundColor = '0;
	localparam depthT farDepth = '1;

	// edge function of a->b at point p and the doubled signed area
	function automatic areaT edgeFn(input coordT ax, input coordT ay, input coordT bx,
			input coordT by, input coordT px, input coordT py);
		areaT dbx;
		areaT dby;
		areaT dpx;
		areaT dpy;
		dbx = {10'd0, bx} - {10'd0, ax};
		dby = {10'd0, by} - {10'd0, ay};
		dpx = {10'd0, px} - {10'd0, ax};
		dpy = {10'd0, py} - {10'd0, ay};
		return dbx * dpy - dby * dpx;
	endfunction

endpackage

`default_nettype wire

//--- hw/triangleStore.sv
`default_nettype none

module triangleStore import rasterPkg::*; #(
	parameter int triAddrWidth = 4
) (
	input wire logic BOARD_CLK,
	input wire logic arstN,
	input wire logic loadEn,
	input wire logic [triAddrWidth-1:0] loadAddr,
	input wire triangleT loadData,
	input wire logic [triAddrWidth-1:0] readAddr,
	output triangleT readData
);

	localparam int depth = 2 ** triAddrWidth;

	triangleT mem [depth];
	logic writeEn;

	// host writes are dropped while the system sits in reset
	assign writeEn = loadEn & arstN;

	always_ff @(posedge BOARD_CLK) begin
		if (writeEn) begin
			mem[loadAddr] <= loadData;
		end
		readData <= mem[readAddr];  // registered read as in block RAM
	end

endmodule

`default_nettype wire

//--- hw/rasterSequencer.sv
`default_nettype none

module rasterSequencer import rasterPkg::*; #(
	parameter int triAddrWidth = 4
) (
	input wire logic BOARD_CLK,
	input wire logic arstN,
	input wire logic startRasterizing,
	input wire logic [triAddrWidth:0] triangleCount,
	input wire triangleT readData,
	input wire logic leftDone,
	input wire logic rightDone,
	input wire logic frameDone,
	output logic busy,
	output logic [triAddrWidth-1:0] readAddr,
	output logic clearStart,
	output logic shadeStart,
	output coordT x0,
	output coordT y0,
	output coordT x1,
	output coordT y1,
	output coordT x2,
	output coordT y2,
	output coordT boxMinX,
	output coordT boxMinY,
	output coordT boxMaxX,
	output coordT boxMaxY,
	output depthT triDepth,
	output colorT triColor,
	output logic readoutStart
);

	typedef enum logic [3:0] {
		idle, clear, clearWait, fetch, setup, shade, shadeWait, next, readout, readoutWait
	} stateT;

	stateT state;
	logic [triAddrWidth:0] triTotal;
	areaT triArea;
	logic shadersDone;

	function automatic coordT min3(input coordT a, input coordT b, input coordT c);
		coordT m;
		m = (a < b) ? a : b;
		return (m < c) ? m : c;
	endfunction

	function automatic coordT max3(input coordT a, input coordT b, input coordT c);
		coordT m;
		m = (a > b) ? a : b;
		return (m > c) ? m : c;
	endfunction

	assign shadersDone = leftDone & rightDone;

	assign clearStart = (state == clear);
	assign shadeStart = (state == shade) && (triArea != 0);  // degenerate ones never start
	assign readoutStart = (state == readout);

	always_ff @(posedge BOARD_CLK or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			busy <= 1'b0;
			readAddr <= '0;
		end else begin
			case (state)
				idle: if (startRasterizing) begin
					state <= clear;
					busy <= 1'b1;
					readAddr <= '0;
				end
				clear: state <= clearWait;
				clearWait: if (shadersDone) begin
					state <= (triTotal == 0) ? readout : fetch;
				end
				fetch: state <= setup;  // store output settles here
				setup: state <= shade;
				shade: state <= (triArea == 0) ? next : shadeWait;
				shadeWait: if (shadersDone) begin
					state <= next;
				end
				next: begin
					if ({1'b0, readAddr} + 1'b1 == triTotal) begin
						state <= readout;
					end else begin
						readAddr <= readAddr + 1'b1;
						state <= fetch;
					end
				end
				readout: state <= readoutWait;
				readoutWait: if (frameDone) begin
					state <= idle;
					busy <= 1'b0;
				end
				default: state <= idle;
			endcase
		end
	end

	// triangle setup held steady while the shaders scan
	always_ff @(posedge BOARD_CLK) begin
		if (state == idle && startRasterizing) begin
			triTotal <= triangleCount;
		end
		if (state == setup) begin
			x0 <= readData.x0;
			y0 <= readData.y0;
			x1 <= readData.x1;
			y1 <= readData.y1;
			x2 <= readData.x2;
			y2 <= readData.y2;
			boxMinX <= min3(readData.x0, readData.x1, readData.x2);
			boxMinY <= min3(readData.y0, readData.y1, readData.y2);
			boxMaxX <= max3(readData.x0, readData.x1, readData.x2);
			boxMaxY <= max3(readData.y0, readData.y1, readData.y2);
			triDepth <= readData.depth;
			triColor <= readData.color;
			triArea <= edgeFn(readData.x0, readData.y0, readData.x1, readData.y1,
				readData.x2, readData.y2);
		end
	end

endmodule

`default_nettype wire

//--- hw/nanoTileShader.sv
`default_nettype none

module nanoTileShader import rasterPkg::*; #(
	parameter int tileDim = 8,
	parameter int columnBase = 0
) (
	input wire logic BOARD_CLK,
	input wire logic arstN,
	input wire logic clearStart,
	input wire logic shadeStart,
	input wire coordT x0,
	input wire coordT y0,
	input wire coordT x1,
	input wire coordT y1,
	input wire coordT x2,
	input wire coordT y2,
	input wire coordT boxMinX,
	input wire coordT boxMinY,
	input wire coordT boxMaxX,
	input wire coordT boxMaxY,
	input wire depthT triDepth,
	input wire colorT triColor,
	input wire coordT readX,
	input wire coordT readY,
	output logic shaderDone,
	output colorT readColor
);

	localparam int halfWidth = tileDim / 2;
	localparam int cellCount = halfWidth * tileDim;
	localparam int idxWidth = $clog2(cellCount);
	localparam coordT colLo = coordT'(columnBase);
	localparam coordT colHi = coordT'(columnBase + halfWidth - 1);
	localparam coordT rowHi = coordT'(tileDim - 1);

	typedef enum logic [1:0] {shIdle, clearing, shading} modeT;

	modeT mode;
	colorT colorMem [cellCount];
	depthT depthMem [cellCount];

	logic [idxWidth-1:0] clearIdx;
	logic [idxWidth-1:0] scanIdx;
	logic [idxWidth-1:0] readIdx;
	logic [idxWidth-1:0] writeIdx;
	coordT scanX, scanY;
	coordT clipMinX, clipMaxX, clipMaxY;
	logic boxMiss;
	areaT e0, e1, e2;
	logic covered;
	logic nearer;
	logic memWrite;

	// box clipped to this half
	assign clipMinX = (boxMinX > colLo) ? boxMinX : colLo;
	assign clipMaxX = (boxMaxX < colHi) ? boxMaxX : colHi;
	assign clipMaxY = (boxMaxY < rowHi) ? boxMaxY : rowHi;
	assign boxMiss = (clipMinX > clipMaxX) || (boxMinY > clipMaxY);

	assign scanIdx = idxWidth'(scanY * halfWidth + (scanX - colLo));
	assign readIdx = idxWidth'(readY * halfWidth + (readX - colLo));  // readX is tile-global

	assign e0 = edgeFn(x0, y0, x1, y1, scanX, scanY);
	assign e1 = edgeFn(x1, y1, x2, y2, scanX, scanY);
	assign e2 = edgeFn(x2, y2, x0, y0, scanX, scanY);

	// either winding counts with edges inclusive
	assign covered = (e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0);
	assign nearer = triDepth < depthMem[scanIdx];

	assign memWrite = (mode == clearing) || (mode == shading && !boxMiss && covered && nearer);
	assign writeIdx = (mode == clearing) ? clearIdx : scanIdx;

	always_ff @(posedge BOARD_CLK) begin
		if (memWrite) begin
			colorMem[writeIdx] <= (mode == clearing) ? backgroundColor : triColor;
			depthMem[writeIdx] <= (mode == clearing) ? farDepth : triDepth;
		end
		readColor <= colorMem[readIdx];
	end

	always_ff @(posedge BOARD_CLK or negedge arstN) begin
		if (!arstN) begin
			mode <= shIdle;
			shaderDone <= 1'b1;
			clearIdx <= '0;
			scanX <= '0;
			scanY <= '0;
		end else if (clearStart) begin
			mode <= clearing;
			shaderDone <= 1'b0;
			clearIdx <= '0;
		end else if (shadeStart) begin
			mode <= shading;
			shaderDone <= 1'b0;
			scanX <= clipMinX;
			scanY <= boxMinY;
		end else begin
			case (mode)
				clearing: begin
					if (clearIdx == idxWidth'(cellCount - 1)) begin
						mode <= shIdle;
						shaderDone <= 1'b1;
					end else begin
						clearIdx <= clearIdx + 1'b1;
					end
				end
				shading: begin
					if (boxMiss) begin  // nothing here for this half
						mode <= shIdle;
						shaderDone <= 1'b1;
					end else if (scanX == clipMaxX) begin
						scanX <= clipMinX;
						if (scanY == clipMaxY) begin
							mode <= shIdle;
							shaderDone <= 1'b1;
						end else begin
							scanY <= scanY + 1'b1;
						end
					end else begin
						scanX <= scanX + 1'b1;
					end
				end
				default: mode <= shIdle;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hw/tileReadout.sv
`default_nettype none

module tileReadout import rasterPkg::*; #(
	parameter int tileDim = 8
) (
	input wire logic BOARD_CLK,
	input wire logic arstN,
	input wire logic readoutStart,
	input wire colorT leftColor,
	input wire colorT rightColor,
	output coordT readX,
	output coordT readY,
	output logic pixelValid,
	output coordT pixelX,
	output coordT pixelY,
	output colorT pixelColor,
	output logic frameDone
);

	localparam coordT lastPos = coordT'(tileDim - 1);
	localparam coordT halfWidth = coordT'(tileDim / 2);

	logic active;

	// left half comes from the left shader
	assign pixelColor = (pixelX < halfWidth) ? leftColor : rightColor;

	always_ff @(posedge BOARD_CLK or negedge arstN) begin
		if (!arstN) begin
			active <= 1'b0;
			readX <= '0;
			readY <= '0;
			pixelValid <= 1'b0;
			pixelX <= '0;
			pixelY <= '0;
			frameDone <= 1'b0;
		end else begin
			pixelValid <= active;  // lines up with the registered shader read
			pixelX <= readX;
			pixelY <= readY;
			frameDone <= pixelValid & ~active;
			if (readoutStart) begin
				active <= 1'b1;
				readX <= '0;
				readY <= '0;
			end else if (active) begin
				if (readX == lastPos) begin
					readX <= '0;
					readY <= readY + 1'b1;
					if (readY == lastPos) begin
						active <= 1'b0;
					end
				end else begin
					readX <= readX + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/tileRasterizer.sv
`default_nettype none

module tileRasterizer import rasterPkg::*; #(
	parameter int tileDim = 8,
	parameter int triAddrWidth = 4
) (
	input wire logic BOARD_CLK,
	input wire logic arstN,
	input wire logic loadEn,
	input wire logic [triAddrWidth-1:0] loadAddr,
	input wire triangleT loadData,
	input wire logic [triAddrWidth:0] triangleCount,
	input wire logic startRasterizing,
	output logic busy,
	output logic pixelValid,
	output coordT pixelX,
	output coordT pixelY,
	output colorT pixelColor,
	output logic frameDone
);

	logic [triAddrWidth-1:0] readAddr;
	triangleT readData;
	logic clearStart, shadeStart, readoutStart;
	logic leftDone, rightDone;
	coordT x0, y0, x1, y1, x2, y2;
	coordT boxMinX, boxMinY, boxMaxX, boxMaxY;
	depthT triDepth;
	colorT triColor;
	coordT readX, readY;
	colorT leftColor, rightColor;

	triangleStore #(.triAddrWidth(triAddrWidth)) store (
		.BOARD_CLK, .arstN, .loadEn, .loadAddr, .loadData, .readAddr, .readData
	);

	rasterSequencer #(.triAddrWidth(triAddrWidth)) sequencer (
		.BOARD_CLK, .arstN, .startRasterizing, .triangleCount, .readData,
		.leftDone, .rightDone, .frameDone, .busy, .readAddr, .clearStart, .shadeStart,
		.x0, .y0, .x1, .y1, .x2, .y2, .boxMinX, .boxMinY, .boxMaxX, .boxMaxY,
		.triDepth, .triColor, .readoutStart
	);

	nanoTileShader #(.tileDim(tileDim), .columnBase(0)) leftShader (
		.BOARD_CLK, .arstN, .clearStart, .shadeStart,
		.x0, .y0, .x1, .y1, .x2, .y2, .boxMinX, .boxMinY, .boxMaxX, .boxMaxY,
		.triDepth, .triColor, .readX, .readY,
		.shaderDone(leftDone), .readColor(leftColor)
	);

	nanoTileShader #(.tileDim(tileDim), .columnBase(tileDim / 2)) rightShader (
		.BOARD_CLK, .arstN, .clearStart, .shadeStart,
		.x0, .y0, .x1, .y1, .x2, .y2, .boxMinX, .boxMinY, .boxMaxX, .boxMaxY,
		.triDepth, .triColor, .readX, .readY,
		.shaderDone(rightDone), .readColor(rightColor)
	);

	tileReadout #(.tileDim(tileDim)) readout (
		.BOARD_CLK, .arstN, .readoutStart, .leftColor, .rightColor,
		.readX, .readY, .pixelValid, .pixelX, .pixelY, .pixelColor, .frameDone
	);

endmodule

`default_nettype wire

//--- bench/tileRasterizer_checker.sv
`default_nettype none

module tileRasterizer_checker (
	input wire logic BOARD_CLK,
	input wire logic arstN,
	input wire logic busy,
	input wire logic pixelValid,
	input wire logic frameDone,
	input wire logic shadeStart,
	input wire logic leftDone,
	input wire logic rightDone
);
	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0;  // failed assertions so far

	validWhileBusy: assert property (@(posedge BOARD_CLK) disable iff (!arstN)
		pixelValid |-> busy)
		else begin
			$error("pixelValid is high while busy is low");
			failCount++;
		end

	frameDonePulse: assert property (@(posedge BOARD_CLK) disable iff (!arstN)
		frameDone |=> !frameDone)
		else begin
			$error("frameDone lasted longer than one cycle");
			failCount++;
		end

	// both shaders must be idle before a new triangle starts
	shadeWhenIdle: assert property (@(posedge BOARD_CLK) disable iff (!arstN)
		shadeStart |-> (leftDone && rightDone))
		else begin
			$error("shadeStart came while a shader was still busy");
			failCount++;
		end

	busyAfterFrame: assert property (@(posedge BOARD_CLK) disable iff (!arstN)
		frameDone |=> !busy)
		else begin
			$error("busy did not fall on the cycle after frameDone");
			failCount++;
		end

endmodule

bind tileRasterizer tileRasterizer_checker rasterChecks (.*);

`default_nettype wire

//--- bench/tileRasterizerTb.sv
`default_nettype none

module tileRasterizerTb import rasterPkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int tileDim = 8;
	localparam int triAddrWidth = 4;
	localparam int maxTriangles = 2 ** triAddrWidth;
	localparam int pixelCount = tileDim * tileDim;
	localparam int totalFrames = 13;
	// frame budget from clear scan, worst case triangles, readout, idle window and loading
	localparam int clearCycles = (tileDim / 2) * tileDim + 3;
	localparam int readoutCycles = pixelCount + 3;
	localparam int settleCycles = clearCycles + readoutCycles + 8;  // room for a stray frame
	localparam int frameBudget = clearCycles + 64 * maxTriangles + readoutCycles
		+ settleCycles + 40;
	localparam int cycleLimit = totalFrames * frameBudget + 20;

	logic BOARD_CLK;
	logic arstN;
	logic loadEn;
	logic [triAddrWidth-1:0] loadAddr;
	triangleT loadData;
	logic [triAddrWidth:0] triangleCount;
	logic startRasterizing;
	logic busy;
	logic pixelValid;
	coordT pixelX;
	coordT pixelY;
	colorT pixelColor;
	logic frameDone;

	triangleT scene [maxTriangles];  // current triangle list
	int sceneCount;
	colorT capturedColor [pixelCount];
	colorT savedColor [pixelCount];
	logic validBefore = 1'b0;  // pixelValid one cycle back
	int pixelIdx = 0;
	int framesSeen = 0;
	int errorCount = 0;
	int checkTotal = 0;
	int cycleCount = 0;
	integer seed = 32'h6233_3f4b;

	tileRasterizer #(.tileDim(tileDim), .triAddrWidth(triAddrWidth)) tileRasterizer_i (
		.BOARD_CLK, .arstN, .loadEn, .loadAddr, .loadData, .triangleCount,
		.startRasterizing, .busy, .pixelValid, .pixelX, .pixelY, .pixelColor, .frameDone
	);

	initial begin
		BOARD_CLK = 1'b0;
		forever #10 BOARD_CLK = ~BOARD_CLK;
	end

	always @(posedge BOARD_CLK) cycleCount++;

	initial begin : watchdog
		wait (cycleCount >= cycleLimit);
		$display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
		$display("Test failures found");
		$finish;
	end

	function automatic triangleT makeTriangle(input int ax, input int ay, input int bx,
			input int by, input int cx, input int cy, input int depth, input int color);
		triangleT t;
		t.x0 = coordT'(ax);
		t.y0 = coordT'(ay);
		t.x1 = coordT'(bx);
		t.y1 = coordT'(by);
		t.x2 = coordT'(cx);
		t.y2 = coordT'(cy);
		t.depth = depthT'(depth);
		t.color = colorT'(color);
		return t;
	endfunction

	// cross product of a->b with a->p
	function automatic int edgeValue(input int ax, input int ay, input int bx, input int by,
			input int px, input int py);
		return (bx - ax) * (py - ay) - (by - ay) * (px - ax);
	endfunction

	// p lies between the smallest and the largest of a, b, c
	function automatic bit inSpan(input int p, input int a, input int b, input int c);
		return (p >= a || p >= b || p >= c) && (p <= a || p <= b || p <= c);
	endfunction

	// expected colour of one tile pixel after the whole list is drawn
	function automatic colorT referencePixel(input triangleT list [maxTriangles],
			input int count, input int px, input int py);
		colorT color;
		depthT depth;
		triangleT t;
		int area;
		int e0;
		int e1;
		int e2;
		color = backgroundColor;
		depth = farDepth;
		for (int i = 0; i < count; i++) begin
			t = list[i];
			area = edgeValue(t.x0, t.y0, t.x1, t.y1, t.x2, t.y2);
			e0 = edgeValue(t.x0, t.y0, t.x1, t.y1, px, py);
			e1 = edgeValue(t.x1, t.y1, t.x2, t.y2, px, py);
			e2 = edgeValue(t.x2, t.y2, t.x0, t.y0, px, py);
			if (area != 0 && inSpan(px, t.x0, t.x1, t.x2) && inSpan(py, t.y0, t.y1, t.y2)
					&& ((e0 >= 0 && e1 >= 0 && e2 >= 0) || (e0 <= 0 && e1 <= 0 && e2 <= 0))
					&& t.depth < depth) begin
				color = t.color;
				depth = t.depth;
			end
		end
		return color;
	endfunction

	task automatic checkColor(input colorT got, input colorT expected, input string what);
		checkTotal++;
		if (got !== expected) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkCoord(input coordT got, input coordT expected, input string what);
		checkTotal++;
		if (got !== expected) begin
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
			errorCount++;
		end
	endtask

	task automatic checkCount(input int got, input int expected, input string what);
		checkTotal++;
		if (got != expected) begin
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, expected);
			errorCount++;
		end
	endtask

	// registered outputs are settled at the falling edge
	always @(negedge BOARD_CLK) begin : compareStream
		int px;
		int py;
		px = pixelIdx % tileDim;
		py = pixelIdx / tileDim;
		if (arstN && pixelValid) begin
			checkCoord(pixelX, coordT'(px), "pixelX");
			checkCoord(pixelY, coordT'(py), "pixelY");
			checkColor(pixelColor, referencePixel(scene, sceneCount, px, py),
				$sformatf("colour at (%0d,%0d)", px, py));
			capturedColor[pixelIdx % pixelCount] = pixelColor;
			pixelIdx++;
		end
		if (arstN && validBefore && !pixelValid && !frameDone) begin
			$display("pixel stream stopped at %0t without frameDone right after it", $time);
			errorCount++;
		end
		if (arstN && frameDone) begin
			if (!validBefore) begin
				$display("frameDone at %0t did not follow the last valid pixel", $time);
				errorCount++;
			end
			checkCount(pixelIdx, pixelCount, "valid pixels in the frame");
			pixelIdx = 0;
			framesSeen++;
		end
		validBefore = arstN && pixelValid;
	end

	task automatic loadScene(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge BOARD_CLK);
			loadEn = 1'b1;
			loadAddr = triAddrWidth'(i);
			loadData = scene[i];
		end
		@(negedge BOARD_CLK);
		loadEn = 1'b0;
	endtask

	// load, start, wait for the stream, report one line
	task automatic runFrame(input string name, input int count, input bit pokeWhileBusy);
		int errorsBefore;
		int framesBefore;
		errorsBefore = errorCount;
		framesBefore = framesSeen;
		sceneCount = count;
		loadScene(count);
		@(negedge BOARD_CLK);
		triangleCount = (triAddrWidth + 1)'(count);
		startRasterizing = 1'b1;
		@(negedge BOARD_CLK);
		startRasterizing = 1'b0;
		if (!busy) begin
			$display("busy did not rise after the start pulse in %s", name);
			errorCount++;
		end
		if (pokeWhileBusy) begin  // must be ignored
			repeat (4) @(negedge BOARD_CLK);
			startRasterizing = 1'b1;
			@(negedge BOARD_CLK);
			startRasterizing = 1'b0;
		end
		wait (framesSeen != framesBefore);
		repeat (8) @(negedge BOARD_CLK);
		if (busy) begin
			$display("busy was still high after the frame ended in %s", name);
			errorCount++;
		end
		repeat (settleCycles) @(negedge BOARD_CLK);  // a second frame would finish here
		checkCount(framesSeen - framesBefore, 1, "frames per start");
		$display("test %-22s %s", name, (errorCount == errorsBefore) ? "ok" : "FAILED");
	endtask

	task automatic fillRandomScene(input int count);
		for (int i = 0; i < count; i++) begin
			scene[i] = makeTriangle($random(seed) & 7, $random(seed) & 7, $random(seed) & 7,
				$random(seed) & 7, $random(seed) & 7, $random(seed) & 7,
				$random(seed) & 15, ($random(seed) & 16'hffff) | 1);  // small depths force ties
		end
	endtask

	initial begin : stimulus
		int errorsBefore;
		int totalErrors;
		int count;
		arstN = 1'b0;
		loadEn = 1'b0;
		loadAddr = '0;
		loadData = '0;
		triangleCount = '0;
		startRasterizing = 1'b0;
		sceneCount = 0;
		repeat (8) @(posedge BOARD_CLK);
		@(negedge BOARD_CLK);
		arstN = 1'b1;
		repeat (2) @(negedge BOARD_CLK);

		runFrame("empty scene", 0, 1'b0);

		scene[0] = makeTriangle(1, 1, 6, 2, 3, 6, 40, 16'h1234);
		runFrame("clockwise triangle", 1, 1'b0);
		savedColor = capturedColor;
		scene[0] = makeTriangle(1, 1, 3, 6, 6, 2, 40, 16'h1234);
		runFrame("anticlockwise triangle", 1, 1'b0);
		errorsBefore = errorCount;
		for (int i = 0; i < pixelCount; i++) begin
			checkColor(capturedColor[i], savedColor[i], $sformatf("winding pixel %0d", i));
		end
		$display("test %-22s %s", "same set both windings",
			(errorCount == errorsBefore) ? "ok" : "FAILED");

		scene[0] = makeTriangle(0, 0, 7, 0, 0, 7, 200, 16'hf800);
		scene[1] = makeTriangle(2, 2, 7, 3, 3, 7, 50, 16'h07e0);
		runFrame("near triangle last", 2, 1'b0);
		scene[0] = makeTriangle(2, 2, 7, 3, 3, 7, 50, 16'h07e0);
		scene[1] = makeTriangle(0, 0, 7, 0, 0, 7, 200, 16'hf800);
		runFrame("near triangle first", 2, 1'b0);
		scene[0] = makeTriangle(0, 0, 7, 0, 0, 7, 100, 16'h001f);
		scene[1] = makeTriangle(7, 7, 1, 3, 3, 1, 100, 16'hffe0);  // overlaps the first
		runFrame("equal depth", 2, 1'b0);

		scene[0] = makeTriangle(0, 0, 4, 0, 0, 4, 300, 16'h0f0f);
		scene[1] = makeTriangle(0, 0, 3, 3, 7, 7, 1, 16'hdead);  // collinear
		scene[2] = makeTriangle(5, 5, 5, 5, 5, 5, 1, 16'hbeef);  // single point
		scene[3] = makeTriangle(7, 7, 3, 7, 7, 2, 300, 16'h5a5a);
		runFrame("degenerate skip", 4, 1'b0);

		for (int f = 0; f < 6; f++) begin
			count = ($random(seed) & 15) + 1;
			fillRandomScene(count);
			runFrame($sformatf("random frame %0d", f), count, 1'b1);
		end

		totalErrors = errorCount + tileRasterizer_i.rasterChecks.failCount;
		$display("%0d checks, %0d errors, %0d frames", checkTotal, totalErrors, framesSeen);
		if (totalErrors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
hw/rasterPkg.sv
hw/triangleStore.sv
hw/rasterSequencer.sv
hw/nanoTileShader.sv
hw/tileReadout.sv
hw/tileRasterizer.sv
bench/tileRasterizer_checker.sv
bench/tileRasterizerTb.sv
